// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_axi_bridge
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/axi_pkg.sv
`default_nettype none

// axi side field types and fixed codes
package axi_pkg;

    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [31:0] axi_data_t;  // one data beat
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [2:0]  axi_size_t;  // log2 bytes per beat

    // burst lengths used by the bridge
    localparam axi_len_t AXI_LEN_LINE = 8'd3;  // four beats
    localparam axi_len_t AXI_LEN_WORD = 8'd0;  // single beat

    // every beat is a full 32-bit word
    localparam axi_size_t AXI_SIZE_WORD = 3'd2;

    // transaction ids, instruction fetch vs data
    localparam logic [3:0] AXI_ID_INST = 4'd0;
    localparam logic [3:0] AXI_ID_DATA = 4'd1;

    // default id width, overridable from the top
    localparam int AXI_ID_W = 4;

endpackage

`default_nettype wire

// File: design/cache_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// top level, icache and dcache ports to one axi master
module cache_axi_bridge
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int ID_W = AXI_ID_W
) (
    input  wire logic        clk,
    input  wire logic        reset,
    // icache read
    input  wire logic        icache_rd_req,
    input  wire req_type_t   icache_rd_type,
    input  wire axi_addr_t   icache_rd_addr,
    output logic             icache_rd_rdy,
    output logic             icache_ret_valid,
    output logic             icache_ret_last,
    output cache_word_t      icache_ret_data,
    // dcache read
    input  wire logic        dcache_rd_req,
    input  wire req_type_t   dcache_rd_type,
    input  wire axi_addr_t   dcache_rd_addr,
    output logic             dcache_rd_rdy,
    output logic             dcache_ret_valid,
    output logic             dcache_ret_last,
    output cache_word_t      dcache_ret_data,
    // dcache write
    input  wire logic        dcache_wr_req,
    input  wire req_type_t   dcache_wr_type,
    input  wire axi_addr_t   dcache_wr_addr,
    input  wire cache_strb_t dcache_wr_strb,
    input  wire cache_line_u dcache_wr_data,
    output logic             dcache_wr_rdy,
    // axi read
    output logic [ID_W-1:0]  arid,
    output axi_addr_t        araddr,
    output axi_len_t         arlen,
    output axi_size_t        arsize,
    output logic             arvalid,
    input  wire logic        arready,
    input  wire axi_data_t   rdata,
    input  wire logic        rlast,
    input  wire logic        rvalid,
    output logic             rready,
    // axi write
    output logic [ID_W-1:0]  awid,
    output axi_addr_t        awaddr,
    output axi_len_t         awlen,
    output axi_size_t        awsize,
    output logic             awvalid,
    input  wire logic        awready,
    output axi_data_t        wdata,
    output cache_strb_t      wstrb,
    output logic             wlast,
    output logic             wvalid,
    input  wire logic        wready,
    input  wire logic        bvalid,
    output logic             bready
);

    rd_txn_if rd_txn ();  // ar side to r side

    read_arbiter #(.ID_W(ID_W)) u_read_arbiter (
        .clk            (clk),
        .reset          (reset),
        .icache_rd_req  (icache_rd_req),
        .icache_rd_type (icache_rd_type),
        .icache_rd_addr (icache_rd_addr),
        .icache_rd_rdy  (icache_rd_rdy),
        .dcache_rd_req  (dcache_rd_req),
        .dcache_rd_type (dcache_rd_type),
        .dcache_rd_addr (dcache_rd_addr),
        .dcache_rd_rdy  (dcache_rd_rdy),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arvalid        (arvalid),
        .arready        (arready),
        .txn            (rd_txn.arbiter)
    );

    read_return u_read_return (
        .clk              (clk),
        .reset            (reset),
        .rdata            (rdata),
        .rlast            (rlast),
        .rvalid           (rvalid),
        .rready           (rready),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_last  (icache_ret_last),
        .icache_ret_data  (icache_ret_data),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret_last  (dcache_ret_last),
        .dcache_ret_data  (dcache_ret_data),
        .txn              (rd_txn.returner)
    );

    // write path shares nothing with the read side
    write_engine #(.ID_W(ID_W)) u_write_engine (
        .clk            (clk),
        .reset          (reset),
        .dcache_wr_req  (dcache_wr_req),
        .dcache_wr_type (dcache_wr_type),
        .dcache_wr_addr (dcache_wr_addr),
        .dcache_wr_strb (dcache_wr_strb),
        .dcache_wr_data (dcache_wr_data),
        .dcache_wr_rdy  (dcache_wr_rdy),
        .awid           (awid),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .awsize         (awsize),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wlast          (wlast),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bready         (bready)
    );

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

// cache side request and data types
package cache_pkg;

    typedef logic [2:0] req_type_t;   // request kind from the cache
    localparam req_type_t REQ_LINE = 3'b100;  // anything else is one word

    typedef logic [31:0] cache_word_t;
    typedef logic [3:0]  cache_strb_t;  // byte enables

    localparam int LINE_WORDS = 4;  // words per cache line

    // one line, flat or per beat
    // beat[0] sits in the low word and goes out first
    typedef union packed {
        logic [LINE_WORDS*32-1:0]      flat;
        cache_word_t [LINE_WORDS-1:0]  beat;
    } cache_line_u;

    // which cache owns the read in flight
    typedef enum logic {
        OWNER_INST = 1'b0,
        OWNER_DATA = 1'b1
    } rd_owner_t;

endpackage

`default_nettype wire

// File: design/rd_txn_if.sv
`timescale 1ns/1ps
`default_nettype none

// hand-off between read address side and read data side
interface rd_txn_if
    import cache_pkg::*;
();

    logic      start;  // pulse on ar handshake
    rd_owner_t owner;  // held for the whole read
    logic      busy;   // read outstanding
    logic      done;   // pulse on last accepted beat

    modport arbiter (
        output start,
        output owner,
        output busy,
        input  done
    );

    modport returner (
        input  start,
        input  owner,
        input  busy,
        output done
    );

endinterface

`default_nettype wire

// File: design/read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// picks icache or dcache read, drives ar channel
module read_arbiter
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int ID_W = AXI_ID_W
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       icache_rd_req,
    input  wire req_type_t  icache_rd_type,
    input  wire axi_addr_t  icache_rd_addr,
    output logic            icache_rd_rdy,
    input  wire logic       dcache_rd_req,
    input  wire req_type_t  dcache_rd_type,
    input  wire axi_addr_t  dcache_rd_addr,
    output logic            dcache_rd_rdy,
    output logic [ID_W-1:0] arid,
    output axi_addr_t       araddr,
    output axi_len_t        arlen,
    output axi_size_t       arsize,
    output logic            arvalid,
    input  wire logic       arready,
    rd_txn_if.arbiter       txn
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } arb_state_t;

    arb_state_t      state;
    logic            arvalid_q;
    logic            grant_d;   // data cache wins ties
    logic            grant_i;
    logic [ID_W-1:0] arid_q;
    axi_addr_t       araddr_q;
    axi_len_t        arlen_q;
    rd_owner_t       owner_q;

    assign grant_d = (state == ST_IDLE) && dcache_rd_req;
    assign grant_i = (state == ST_IDLE) && icache_rd_req && !dcache_rd_req;

    assign dcache_rd_rdy = grant_d;  // same cycle as the request
    assign icache_rd_rdy = grant_i;

    // control state
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ST_IDLE;
            arvalid_q <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (grant_d || grant_i)
                    begin
                        state     <= ST_ACTIVE;
                        arvalid_q <= 1'b1;  // address goes out next cycle
                    end
                end
                ST_ACTIVE:
                begin
                    if (arvalid_q && arready)
                        arvalid_q <= 1'b0;  // address taken
                    if (txn.done)
                        state <= ST_IDLE;   // free again next cycle
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload, only loaded on a grant
    always_ff @(posedge clk)
    begin
        if (grant_d)
        begin
            araddr_q <= {dcache_rd_addr[31:2], 2'b00};  // word aligned
            arid_q   <= ID_W'(AXI_ID_DATA);
            arlen_q  <= (dcache_rd_type == REQ_LINE) ? AXI_LEN_LINE : AXI_LEN_WORD;
            owner_q  <= OWNER_DATA;
        end
        else if (grant_i)
        begin
            araddr_q <= icache_rd_addr;  // fetch address as is
            arid_q   <= ID_W'(AXI_ID_INST);
            arlen_q  <= (icache_rd_type == REQ_LINE) ? AXI_LEN_LINE : AXI_LEN_WORD;
            owner_q  <= OWNER_INST;
        end
    end

    assign arid    = arid_q;
    assign araddr  = araddr_q;
    assign arlen   = arlen_q;
    assign arsize  = AXI_SIZE_WORD;  // always full words
    assign arvalid = arvalid_q;

    assign txn.start = arvalid_q && arready;  // handshake pulse
    assign txn.owner = owner_q;
    assign txn.busy  = (state == ST_ACTIVE);

endmodule

`default_nettype wire

// File: design/read_return.sv
`timescale 1ns/1ps
`default_nettype none

// takes r beats and hands them to the owning cache
module read_return
    import axi_pkg::*;
    import cache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire axi_data_t rdata,
    input  wire logic      rlast,
    input  wire logic      rvalid,
    output logic           rready,
    output logic           icache_ret_valid,
    output logic           icache_ret_last,
    output cache_word_t    icache_ret_data,
    output logic           dcache_ret_valid,
    output logic           dcache_ret_last,
    output cache_word_t    dcache_ret_data,
    rd_txn_if.returner     txn
);

    logic        rready_q;
    logic        beat_fire;  // beat accepted this cycle
    logic        ivalid_q;
    logic        dvalid_q;
    logic        last_q;
    cache_word_t data_q;

    assign beat_fire = rvalid && rready_q && txn.busy;
    assign txn.done  = beat_fire && rlast;  // ends the read

    // rready from after the ar handshake up to the last beat
    always_ff @(posedge clk)
    begin
        if (reset)
            rready_q <= 1'b0;
        else if (txn.start)
            rready_q <= 1'b1;
        else if (txn.done)
            rready_q <= 1'b0;
    end

    // one valid strobe per beat, steered by owner
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ivalid_q <= 1'b0;
            dvalid_q <= 1'b0;
        end
        else
        begin
            ivalid_q <= beat_fire && (txn.owner == OWNER_INST);
            dvalid_q <= beat_fire && (txn.owner == OWNER_DATA);
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_fire)
        begin
            data_q <= rdata;
            last_q <= rlast;
        end
    end

    assign rready = rready_q;

    assign icache_ret_valid = ivalid_q;
    assign icache_ret_last  = ivalid_q && last_q;
    assign icache_ret_data  = data_q;  // shared, valid tells whose it is
    assign dcache_ret_valid = dvalid_q;
    assign dcache_ret_last  = dvalid_q && last_q;
    assign dcache_ret_data  = data_q;

endmodule

`default_nettype wire

// File: design/write_engine.sv
`timescale 1ns/1ps
`default_nettype none

// dcache write path, aw then w beats then b
module write_engine
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int ID_W = AXI_ID_W
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        dcache_wr_req,
    input  wire req_type_t   dcache_wr_type,
    input  wire axi_addr_t   dcache_wr_addr,
    input  wire cache_strb_t dcache_wr_strb,
    input  wire cache_line_u dcache_wr_data,
    output logic             dcache_wr_rdy,
    output logic [ID_W-1:0]  awid,
    output axi_addr_t        awaddr,
    output axi_len_t         awlen,
    output axi_size_t        awsize,
    output logic             awvalid,
    input  wire logic        awready,
    output axi_data_t        wdata,
    output cache_strb_t      wstrb,
    output logic             wlast,
    output logic             wvalid,
    input  wire logic        wready,
    input  wire logic        bvalid,
    output logic             bready
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t   state;
    logic        capture;   // request taken this cycle
    logic [1:0]  beat_cnt;  // current w beat
    axi_addr_t   awaddr_q;
    axi_len_t    awlen_q;
    cache_strb_t strb_q;
    cache_line_u line_q;

    assign dcache_wr_rdy = (state == WR_IDLE);
    assign capture       = dcache_wr_rdy && dcache_wr_req;

    // last beat once the counter reaches the burst length
    // awlen is 0 or 3, so its low bits are enough
    assign wlast = (beat_cnt == awlen_q[1:0]);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= WR_IDLE;
            beat_cnt <= 2'd0;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    if (capture)
                    begin
                        state    <= WR_ADDR;
                        beat_cnt <= 2'd0;
                    end
                end
                WR_ADDR:
                begin
                    if (awready)
                        state <= WR_DATA;  // wvalid from next cycle
                end
                WR_DATA:
                begin
                    if (wready)
                    begin
                        if (wlast)
                            state <= WR_RESP;
                        else
                            beat_cnt <= beat_cnt + 2'd1;  // next word
                    end
                end
                WR_RESP:
                begin
                    if (bvalid)
                        state <= WR_IDLE;  // rdy back next cycle
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // payload held from capture until the response
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            awaddr_q <= dcache_wr_addr;
            awlen_q  <= (dcache_wr_type == REQ_LINE) ? AXI_LEN_LINE : AXI_LEN_WORD;
            strb_q   <= dcache_wr_strb;  // same enables on every beat
            line_q   <= dcache_wr_data;
        end
    end

    assign awid    = ID_W'(AXI_ID_DATA);  // writes are always data
    assign awaddr  = awaddr_q;
    assign awlen   = awlen_q;
    assign awsize  = AXI_SIZE_WORD;
    assign awvalid = (state == WR_ADDR);

    assign wdata  = line_q.beat[beat_cnt];  // low word first
    assign wstrb  = strb_q;
    assign wvalid = (state == WR_DATA);

    assign bready = (state == WR_RESP);

endmodule

`default_nettype wire

// File: sources.f
design/axi_pkg.sv
design/cache_pkg.sv
design/rd_txn_if.sv
design/read_arbiter.sv
design/read_return.sv
design/write_engine.sv
design/cache_axi_bridge.sv
tb/bridge_checker.sv
tb/tb_cache_axi_bridge.sv

// File: tb/bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

// axi handshake rules seen at the bridge boundary
module bridge_checker
    import axi_pkg::*;
#(
    parameter int ID_W = AXI_ID_W
) (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            icache_rd_rdy,
    input wire logic            dcache_rd_rdy,
    input wire logic            icache_ret_valid,
    input wire logic            dcache_ret_valid,
    input wire logic [ID_W-1:0] arid,
    input wire axi_addr_t       araddr,
    input wire axi_len_t        arlen,
    input wire logic            arvalid,
    input wire logic            arready,
    input wire logic            rready,
    input wire axi_addr_t       awaddr,
    input wire axi_len_t        awlen,
    input wire logic            awvalid,
    input wire logic            awready,
    input wire axi_data_t       wdata,
    input wire logic [3:0]      wstrb,
    input wire logic            wlast,
    input wire logic            wvalid,
    input wire logic            wready,
    input wire logic            bready
);

    // valid must wait for ready with the payload frozen
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arid))
        else $error("arvalid or ar payload changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else $error("awvalid or aw payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
        else $error("wvalid or w payload changed before wready");

    // data cache has priority, one grant at a time
    one_grant: assert property (@(posedge clk) disable iff (reset)
        !(icache_rd_rdy && dcache_rd_rdy))
        else $error("both read ports granted in one cycle");

    quiet_after_reset: assert property (@(posedge clk)
        $past(reset) |-> !(arvalid || awvalid || wvalid || rready || bready
                           || icache_ret_valid || dcache_ret_valid))
        else $error("valid output high right after reset");

endmodule

bind cache_axi_bridge bridge_checker #(.ID_W(ID_W)) u_bridge_checker (.*);

`default_nettype wire

// File: tb/bridge_vectors.txt
// op type addr strb line expected, one hex field per token
// op 1 icache read, 2 dcache read, 3 dcache write, 4 both reads (icache addr in line), 0 end
1 0 00000106 0 0 a0000104
2 4 00000203 0 0 a000020ca0000208a0000204a0000200
3 0 00000108 5 11223344 0
2 0 00000108 0 0 a0220144
3 4 00000300 f deadbeefcafef00d0123456789abcdef 0
2 4 00000300 0 0 deadbeefcafef00d0123456789abcdef
1 4 00000300 0 0 deadbeefcafef00d0123456789abcdef
4 0 00000040 0 00000084 a0000084a0000040
3 4 00000020 3 ffffffffeeeeeeeeddddddddcccccccc 0
2 4 00000022 0 0 a000ffffa000eeeea000dddda000cccc
4 0 00000024 0 00000110 a0000110a000dddd
1 0 00000000 0 0 a0000000
0 0 0 0 0 0

// File: tb/tb_cache_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_axi_bridge
    import axi_pkg::*;
    import cache_pkg::*;
;

    localparam int ID_W    = 4;
    localparam int TIMEOUT = 200;  // cycles per wait
    localparam int MAX_REC = 32;   // records in the vector file

    logic clk;
    logic reset;
    logic icache_rd_req, dcache_rd_req, dcache_wr_req;
    req_type_t icache_rd_type, dcache_rd_type, dcache_wr_type;
    axi_addr_t icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
    cache_strb_t dcache_wr_strb;
    cache_line_u dcache_wr_data;
    logic icache_rd_rdy, dcache_rd_rdy, dcache_wr_rdy;
    logic icache_ret_valid, icache_ret_last, dcache_ret_valid, dcache_ret_last;
    cache_word_t icache_ret_data, dcache_ret_data;
    logic [ID_W-1:0] arid, awid;
    axi_addr_t araddr, awaddr;
    axi_len_t arlen, awlen;
    axi_size_t arsize, awsize;
    logic arvalid, arready, rlast, rvalid, rready;
    axi_data_t rdata, wdata;
    cache_strb_t wstrb;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    cache_axi_bridge #(.ID_W(ID_W)) DUT (.*);

    // slave memory model state
    axi_data_t mem [0:255];
    logic [127:0] vec_mem [0:6*MAX_REC-1];
    logic [31:0] rng = 32'd70842;
    int ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic rd_active, b_pend;
    int rd_left;
    axi_addr_t rd_addr, wr_addr;
    axi_addr_t ar_addr_q[$], aw_addr_q[$];
    axi_len_t ar_len_q[$], aw_len_q[$];
    logic [ID_W-1:0] ar_id_q[$];
    axi_data_t w_data_q[$];
    logic w_last_q[$];

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pick_delay();
        rng = xorshift32(rng);
        return int'(rng[1:0]);  // 0 to 3 cycles
    endfunction

    // handshakes seen at the rising edge
    always @(posedge clk)
    begin
        if (arvalid && arready)
        begin
            check_size("arsize", arsize, 3'd2);  // word beats only
            ar_addr_q.push_back(araddr);
            ar_len_q.push_back(arlen);
            ar_id_q.push_back(arid);
            rd_addr   = araddr;
            rd_left   = int'(arlen) + 1;
            rd_active = 1'b1;
            ar_cnt    = pick_delay();
        end
        if (rvalid && rready)
        begin
            rd_addr = rd_addr + 4;  // incr burst
            rd_left = rd_left - 1;
            if (rd_left == 0)
                rd_active = 1'b0;
            r_cnt = pick_delay();
        end
        if (awvalid && awready)
        begin
            check_size("awsize", awsize, 3'd2);
            check_id("awid", awid, ID_W'(1));  // writes always carry the data id
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
            wr_addr = awaddr;
            aw_cnt  = pick_delay();
        end
        if (wvalid && wready)
        begin
            for (int b = 0; b < 4; b++)
                if (wstrb[b])
                    mem[wr_addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
            w_data_q.push_back(wdata);
            w_last_q.push_back(wlast);
            wr_addr = wr_addr + 4;
            if (wlast)
                b_pend = 1'b1;
            w_cnt = pick_delay();
        end
        if (bvalid && bready)
        begin
            b_pend = 1'b0;
            b_cnt  = pick_delay();
        end
    end

    // slave outputs change on the falling edge only
    always @(negedge clk)
    begin
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        if (!reset)
        begin
            if (arvalid && !rd_active)
            begin
                if (ar_cnt == 0) arready = 1'b1;
                else ar_cnt--;
            end
            if (rd_active)
            begin
                if (r_cnt == 0)
                begin
                    rvalid = 1'b1;
                    rdata  = mem[rd_addr[9:2]];
                    rlast  = (rd_left == 1);
                end
                else r_cnt--;
            end
            if (awvalid)
            begin
                if (aw_cnt == 0) awready = 1'b1;
                else aw_cnt--;
            end
            if (wvalid)
            begin
                if (w_cnt == 0) wready = 1'b1;
                else w_cnt--;
            end
            if (b_pend)
            begin
                if (b_cnt == 0) bvalid = 1'b1;
                else b_cnt--;
            end
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_word_t got, input cache_word_t exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_size(input string name, input axi_size_t got, input axi_size_t exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] got,
                            input logic [ID_W-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // sample at rising edges until the port grants
    task automatic wait_grant(input bit is_data);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                fail_now("read request was never granted");
        end while (!(is_data ? dcache_rd_rdy : icache_rd_rdy));
    endtask

    task automatic collect(input bit is_data, input int beats, input cache_line_u exp);
        int k;
        int n;
        k = 0;
        n = 0;
        while (k < beats)
        begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                fail_now("read data did not come back in time");
            if (is_data ? icache_ret_valid : dcache_ret_valid)
                fail_now("read data went to the wrong cache");
            if (is_data && dcache_ret_valid)
            begin
                check_word("dcache_ret_data", dcache_ret_data, exp.beat[k]);
                check_flag("dcache_ret_last", dcache_ret_last, k == beats - 1);
                k++;
            end
            else if (!is_data && icache_ret_valid)
            begin
                check_word("icache_ret_data", icache_ret_data, exp.beat[k]);
                check_flag("icache_ret_last", icache_ret_last, k == beats - 1);
                k++;
            end
        end
    endtask

    // data reads aligned with id 1 and fetches unchanged with id 0
    task automatic check_ar(input bit is_data, input req_type_t typ, input axi_addr_t addr);
        if (ar_addr_q.size() == 0)
            fail_now("no read address handshake was seen");
        check_addr("araddr", ar_addr_q.pop_front(), is_data ? {addr[31:2], 2'b00} : addr);
        check_len("arlen", ar_len_q.pop_front(), (typ == REQ_LINE) ? 8'd3 : 8'd0);
        check_id("arid", ar_id_q.pop_front(), is_data ? ID_W'(1) : ID_W'(0));
    endtask

    task automatic read_port(input bit is_data, input req_type_t typ, input axi_addr_t addr,
                             input cache_line_u exp);
        @(negedge clk);
        if (is_data)
        begin
            dcache_rd_req  = 1'b1;
            dcache_rd_type = typ;
            dcache_rd_addr = addr;
        end
        else
        begin
            icache_rd_req  = 1'b1;
            icache_rd_type = typ;
            icache_rd_addr = addr;
        end
        wait_grant(is_data);
        @(negedge clk);
        dcache_rd_req = 1'b0;
        icache_rd_req = 1'b0;
        collect(is_data, (typ == REQ_LINE) ? 4 : 1, exp);
        check_ar(is_data, typ, addr);
    endtask

    // data wins when both caches ask in one idle cycle
    task automatic race_reads(input req_type_t typ, input axi_addr_t daddr,
                              input axi_addr_t iaddr, input cache_line_u exp);
        cache_line_u iexp;
        iexp.flat    = '0;
        iexp.beat[0] = exp.beat[1];
        @(negedge clk);
        dcache_rd_req  = 1'b1;
        dcache_rd_type = typ;
        dcache_rd_addr = daddr;
        icache_rd_req  = 1'b1;
        icache_rd_type = typ;
        icache_rd_addr = iaddr;
        @(posedge clk);
        check_flag("dcache_rd_rdy", dcache_rd_rdy, 1'b1);
        check_flag("icache_rd_rdy", icache_rd_rdy, 1'b0);
        @(negedge clk);
        dcache_rd_req = 1'b0;
        collect(1'b1, 1, exp);
        check_ar(1'b1, typ, daddr);
        // held fetch granted on the edge that brings the data word back
        check_flag("icache_rd_rdy", icache_rd_rdy, 1'b1);
        @(negedge clk);
        icache_rd_req = 1'b0;
        collect(1'b0, 1, iexp);
        check_ar(1'b0, typ, iaddr);
    endtask

    task automatic write_dcache(input req_type_t typ, input axi_addr_t addr,
                                input cache_strb_t strb, input cache_line_u line);
        int n;
        int beats;
        beats = (typ == REQ_LINE) ? 4 : 1;
        @(negedge clk);
        w_data_q.delete();
        w_last_q.delete();
        dcache_wr_req  = 1'b1;
        dcache_wr_type = typ;
        dcache_wr_addr = addr;
        dcache_wr_strb = strb;
        dcache_wr_data = line;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                fail_now("write request was never accepted");
        end while (!dcache_wr_rdy);
        @(negedge clk);
        dcache_wr_req = 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                fail_now("write did not finish in time");
        end while (!dcache_wr_rdy);
        if (aw_addr_q.size() != 1 || w_data_q.size() != beats)
            fail_now("wrong number of write address or data beats");
        check_addr("awaddr", aw_addr_q.pop_front(), addr);
        check_len("awlen", aw_len_q.pop_front(), (typ == REQ_LINE) ? 8'd3 : 8'd0);
        for (int k = 0; k < beats; k++)
        begin
            check_word("wdata", w_data_q[k], line.beat[k]);  // low word first
            check_flag("wlast", w_last_q[k], k == beats - 1);
        end
    endtask

    initial
    begin
        logic [3:0] op;
        cache_line_u line;
        cache_line_u exp;
        req_type_t typ;
        axi_addr_t addr;
        bit finished;
        int idx;
        clk = 1'b0;
        reset = 1'b1;
        icache_rd_req = 1'b0;
        icache_rd_type = '0;
        icache_rd_addr = '0;
        dcache_rd_req = 1'b0;
        dcache_rd_type = '0;
        dcache_rd_addr = '0;
        dcache_wr_req = 1'b0;
        dcache_wr_type = '0;
        dcache_wr_addr = '0;
        dcache_wr_strb = '0;
        dcache_wr_data = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt, rd_left} = '0;
        rd_active = 1'b0;
        b_pend = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = 32'ha000_0000 | (i << 2);  // each word holds its own address
        $readmemh("tb/bridge_vectors.txt", vec_mem);
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        finished = 1'b0;
        idx = 0;
        while (!finished && idx < MAX_REC)
        begin
            op        = vec_mem[6*idx][3:0];
            typ       = vec_mem[6*idx+1][2:0];
            addr      = vec_mem[6*idx+2][31:0];
            line.flat = vec_mem[6*idx+4];
            exp.flat  = vec_mem[6*idx+5];
            case (op)
                4'd0: finished = 1'b1;
                4'd1: read_port(1'b0, typ, addr, exp);
                4'd2: read_port(1'b1, typ, addr, exp);
                4'd3: write_dcache(typ, addr, vec_mem[6*idx+3][3:0], line);
                4'd4: race_reads(typ, addr, line.beat[0], exp);  // fetch addr in line
                default: fail_now("unknown operation in the vector file");
            endcase
            idx++;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
